// File: files.f
hdl/rx_core_pkg.sv
hdl/sample_credit_if.sv
hdl/word_read_if.sv
hdl/rx_frontend.sv
hdl/sample_buffer.sv
hdl/packetizer.sv
hdl/x300_rx_core.sv
tests/x300_rx_core_assertions.sv
tests/tb_x300_rx_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_x300_rx_core
RTL_TOP   ?= x300_rx_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := *** TEST PASSED ***

RTL_SRCS := $(filter hdl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_x300_rx_core.sv
`timescale 1ns/1ps

module tb_x300_rx_core import rx_core_pkg::*; ();

   localparam int BUFF_DEPTH_LOG2 = 4;
   localparam int PKT_WORDS       = 8;
   localparam int DEPTH           = 2**BUFF_DEPTH_LOG2;
   localparam int PKT_SAMPLES     = 2*PKT_WORDS;
   localparam int DRAIN_CYCLES    = 40*PKT_WORDS;
   // up to 5 cycles per sample plus four drains and slack for reset and pps
   localparam int RUN_CYCLES = 5*(10*PKT_SAMPLES + 2*DEPTH + 8) + 4*DRAIN_CYCLES + 300;

   logic        radio_clk = 1'b0;
   logic        i_rst_n   = 1'b0;
   sample_t     i_rx      = '0;
   logic        i_rx_stb  = 1'b0;
   logic        i_pps     = 1'b0;
   logic        i_tready  = 1'b0;
   word_t       o_tdata;
   logic        o_tvalid, o_tlast, o_overflow;

   logic [31:0] lfsr        = 32'h01ec8c57;
   int          ready_mode  = 0;   // 0 high, 1 random, 2 held low
   int          word_budget = -1;  // words the buffer can still take (-1 for no limit)
   int          beat_idx    = 0;   // 0 is the header beat
   int          checks      = 0;
   int          errors      = 0;
   logic        have_low    = 1'b0;
   sample_t     low_sample;
   time_t       low_time;
   time_t       model_time  = '0;  // strobes since reset or pps
   word_t       exp_words[$];
   time_t       exp_times[$];

   x300_rx_core #(
      .BUFF_DEPTH_LOG2(BUFF_DEPTH_LOG2),
      .PKT_WORDS      (PKT_WORDS)
   ) i_x300_rx_core (
      .radio_clk (radio_clk),
      .i_rst_n   (i_rst_n),
      .i_rx      (i_rx),
      .i_rx_stb  (i_rx_stb),
      .i_pps     (i_pps),
      .i_tready  (i_tready),
      .o_tdata   (o_tdata),
      .o_tvalid  (o_tvalid),
      .o_tlast   (o_tlast),
      .o_overflow(o_overflow)
   );

   always #50 radio_clk = ~radio_clk;

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   // taps x^32+x^22+x^2+x+1 and one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          k;
      r = '0;
      for (k = 0; k < n; k++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic tick();
      @(posedge radio_clk);
      i_rx_stb <= 1'b0;
      case (ready_mode)
         0:       i_tready <= 1'b1;
         1:       i_tready <= (rand_bits(1) != 0);  // about half the cycles stalled
         default: i_tready <= 1'b0;
      endcase
   endtask

   // one strobe mirrored into the model
   task automatic strobe_sample();
      sample_t s;
      s = rand_bits(32);
      tick();
      i_rx     <= s;
      i_rx_stb <= 1'b1;
      if (!have_low) begin
         low_sample = s;
         low_time   = model_time;
      end else if (word_budget != 0) begin
         exp_words.push_back({s, low_sample});  // first sample low
         exp_times.push_back(low_time);
         if (word_budget > 0) begin
            word_budget--;
         end
      end
      have_low   = !have_low;
      model_time = model_time + 1;
   endtask

   task automatic send_samples(input int n, input int min_gap);
      int k;
      int gap;
      for (k = 0; k < n; k++) begin
         gap = min_gap + int'(rand_bits(2));
         repeat (gap) tick();
         strobe_sample();
      end
   endtask

   task automatic pulse_pps();
      tick();
      i_pps <= 1'b1;
      repeat (3) tick();
      i_pps      <= 1'b0;
      model_time = '0;
      repeat (5) tick();  // quiet before the next strobe
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_words.size() != 0 || beat_idx != 0) && n < DRAIN_CYCLES) begin
         tick();
         n++;
      end
      if (exp_words.size() != 0 || beat_idx != 0) begin
         $display("drain timed out at %0t, %0d words never came out", $time, exp_words.size());
         errors++;
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic test_done(input int num, input string name, input int mark);
      $display("test %0d %s: %0d errors", num, name, errors - mark);
   endtask

   ////////////////////////////////////////
   // output monitor and model compare
   ////////////////////////////////////////

   always @(negedge radio_clk) begin
      if (i_rst_n && o_tvalid && i_tready) begin  // taken on the next rising edge
         if (exp_words.size() == 0) begin
            $display("beat at %0t while no word was expected", $time);
            errors++;
         end else if (beat_idx == 0) begin
            check_value("o_tdata header", o_tdata, exp_times[0]);  // time of first word
            check_value("o_tlast", 64'(o_tlast), '0);
            beat_idx = 1;
         end else begin
            check_value("o_tdata payload", o_tdata, exp_words.pop_front());
            check_value("o_tlast", 64'(o_tlast), 64'(beat_idx == PKT_WORDS));
            void'(exp_times.pop_front());
            beat_idx = (beat_idx == PKT_WORDS) ? 0 : beat_idx + 1;
         end
      end
   end

   initial begin
      int mark;
      repeat (10) @(posedge radio_clk);
      i_rst_n <= 1'b1;

      mark = errors;  // reset state with nothing driven
      repeat (20) begin
         tick();
         @(negedge radio_clk);
         check_value("o_tvalid", 64'(o_tvalid), '0);
         check_value("o_tlast", 64'(o_tlast), '0);
         check_value("o_overflow", 64'(o_overflow), '0);
      end
      test_done(1, "reset state", mark);

      mark = errors;
      send_samples(4*PKT_SAMPLES, 0);
      wait_drain();
      @(negedge radio_clk);
      check_value("o_overflow", 64'(o_overflow), '0);
      test_done(2, "ordered packets", mark);

      mark = errors;
      pulse_pps();
      send_samples(2*PKT_SAMPLES, 0);
      wait_drain();
      test_done(3, "pps time clear", mark);

      mark = errors;
      ready_mode = 1;
      send_samples(4*PKT_SAMPLES, 1);  // moderate rate so the buffer never fills
      wait_drain();
      ready_mode = 0;
      @(negedge radio_clk);
      check_value("o_overflow", 64'(o_overflow), '0);
      test_done(4, "random stalls", mark);

      mark = errors;
      ready_mode  = 2;
      word_budget = DEPTH;  // header holds and the fifo takes DEPTH words
      send_samples(2*DEPTH + 8, 0);
      repeat (3) tick();
      @(negedge radio_clk);
      check_value("o_overflow", 64'(o_overflow), 64'(1));
      ready_mode = 0;
      wait_drain();
      repeat (20) begin  // dropped words must stay gone
         tick();
         @(negedge radio_clk);
         check_value("o_tvalid", 64'(o_tvalid), '0);
         check_value("o_overflow", 64'(o_overflow), 64'(1));
      end
      test_done(5, "overflow", mark);

      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, i_x300_rx_core.chk_i.fail_cnt);
      if (errors == 0 && i_x300_rx_core.chk_i.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(RUN_CYCLES * 100);
      $display("watchdog expired after %0d cycles, the run stalled", RUN_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: tests/x300_rx_core_assertions.sv
`timescale 1ns/1ps

module x300_rx_core_assertions import rx_core_pkg::*; #(
   parameter int PKT_WORDS = 8
) (
   input logic  radio_clk,
   input logic  i_rst_n,
   input logic  i_tready,
   input word_t o_tdata,
   input logic  o_tvalid,
   input logic  o_tlast,
   input logic  o_overflow
);

   int unsigned fail_cnt = 0;  // read by the testbench at the end
   int          beat_cnt;      // accepted beats in the current packet

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         beat_cnt <= 0;
      end else if (o_tvalid && i_tready) begin
         beat_cnt <= (beat_cnt == PKT_WORDS) ? 0 : beat_cnt + 1;  // header plus payload
      end
   end

   ////////////////////////////////////////
   // stream rules
   ////////////////////////////////////////

   // stalled beat must not move
   stall_stable: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
      else begin
         $error("o_tdata or o_tlast changed while the beat was stalled");
         fail_cnt++;
      end

   // last only on beat PKT_WORDS+1
   tlast_place: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_tvalid && i_tready |-> o_tlast == (beat_cnt == PKT_WORDS))
      else begin
         $error("o_tlast out of place, beat %0d of the packet", beat_cnt);
         fail_cnt++;
      end

   // overflow is sticky
   overflow_sticky: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_overflow |=> o_overflow)
      else begin
         $error("o_overflow fell after rising");
         fail_cnt++;
      end

endmodule

bind x300_rx_core x300_rx_core_assertions #(
   .PKT_WORDS(PKT_WORDS)
) chk_i (
   .radio_clk (radio_clk),
   .i_rst_n   (i_rst_n),
   .i_tready  (i_tready),
   .o_tdata   (o_tdata),
   .o_tvalid  (o_tvalid),
   .o_tlast   (o_tlast),
   .o_overflow(o_overflow)
);

// File: hdl/x300_rx_core.sv
`timescale 1ns/1ps

module x300_rx_core import rx_core_pkg::*; #(
   parameter int BUFF_DEPTH_LOG2 = 4,  // input buffer, log2 words
   parameter int PKT_WORDS       = 8   // payload words per packet
) (
   input  logic    radio_clk,
   input  logic    i_rst_n,
   input  sample_t i_rx,
   input  logic    i_rx_stb,
   input  logic    i_pps,
   input  logic    i_tready,
   output word_t   o_tdata,
   output logic    o_tvalid,
   output logic    o_tlast,
   output logic    o_overflow
);

   sample_credit_if credit_bus ();  // front end -> buffer
   word_read_if     read_bus ();    // buffer -> packetizer

   ////////////////////////////////////////
   // receive channel
   ////////////////////////////////////////

   rx_frontend #(
      .BUFF_DEPTH_LOG2(BUFF_DEPTH_LOG2)
   ) frontend_i (
      .radio_clk (radio_clk),
      .i_rst_n   (i_rst_n),
      .i_rx      (i_rx),
      .i_rx_stb  (i_rx_stb),
      .i_pps     (i_pps),
      .o_overflow(o_overflow),
      .src       (credit_bus.producer)
   );

   sample_buffer #(
      .BUFF_DEPTH_LOG2(BUFF_DEPTH_LOG2)
   ) buffer_i (
      .radio_clk(radio_clk),
      .i_rst_n  (i_rst_n),
      .wr       (credit_bus.buffer),
      .rd       (read_bus.buffer)
   );

   packetizer #(
      .PKT_WORDS(PKT_WORDS)
   ) packetizer_i (
      .radio_clk(radio_clk),
      .i_rst_n  (i_rst_n),
      .rd       (read_bus.consumer),
      .o_tdata  (o_tdata),
      .o_tvalid (o_tvalid),
      .o_tlast  (o_tlast),
      .i_tready (i_tready)
   );

endmodule

// File: hdl/packetizer.sv
`timescale 1ns/1ps

module packetizer import rx_core_pkg::*; #(
   parameter int PKT_WORDS = 8
) (
   input  logic          radio_clk,
   input  logic          i_rst_n,
   word_read_if.consumer rd,
   output word_t         o_tdata,
   output logic          o_tvalid,
   output logic          o_tlast,
   input  logic          i_tready
);

   localparam int CNT_W = $clog2(PKT_WORDS + 1);

   pkt_state_t       state;
   logic [CNT_W-1:0] beat_cnt;   // payload words loaded so far
   logic             out_free;   // output register may take a new beat
   logic             last_word;

   assign out_free  = ~o_tvalid | i_tready;
   assign last_word = (beat_cnt == CNT_W'(PKT_WORDS - 1));

   // a payload word leaves the fifo when it enters the output register
   assign rd.pop = (state != ST_IDLE) & out_free & rd.valid;

   ////////////////////////////////////////
   // header/payload fsm
   ////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state    <= ST_IDLE;
         beat_cnt <= '0;
         o_tvalid <= 1'b0;
         o_tlast  <= 1'b0;
      end else if (out_free) begin
         case (state)
            ST_IDLE: begin
               o_tlast  <= 1'b0;
               o_tvalid <= rd.valid;  // header from the head word's time
               beat_cnt <= '0;
               if (rd.valid) state <= ST_HEADER;
            end
            ST_HEADER, ST_PAYLOAD: begin
               o_tvalid <= rd.valid;  // bubble if the fifo ran dry
               if (rd.valid) begin
                  o_tlast  <= last_word;
                  beat_cnt <= beat_cnt + 1'b1;
                  state    <= last_word ? ST_IDLE : ST_PAYLOAD;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // beat data, held while stalled
   always_ff @(posedge radio_clk) begin
      if (out_free && rd.valid) begin
         o_tdata <= (state == ST_IDLE) ? rd.word_time : rd.word;
      end
   end

endmodule

// File: hdl/sample_buffer.sv
`timescale 1ns/1ps

module sample_buffer import rx_core_pkg::*; #(
   parameter int BUFF_DEPTH_LOG2 = 4
) (
   input  logic            radio_clk,
   input  logic            i_rst_n,
   sample_credit_if.buffer wr,
   word_read_if.buffer     rd
);

   localparam int DEPTH = 2**BUFF_DEPTH_LOG2;

   word_t                      mem_word [DEPTH];
   time_t                      mem_time [DEPTH];
   logic [BUFF_DEPTH_LOG2-1:0] wr_ptr, rd_ptr;   // wrap naturally
   logic [BUFF_DEPTH_LOG2:0]   count;            // 0..DEPTH
   logic                       do_pop;

   assign do_pop = rd.pop & rd.valid;

   // storage, written on every push
   always_ff @(posedge radio_clk) begin
      if (wr.push) begin
         mem_word[wr_ptr] <= wr.word;
         mem_time[wr_ptr] <= wr.word_time;
      end
   end

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr           <= '0;
         rd_ptr           <= '0;
         count            <= '0;
         wr.credit_return <= 1'b0;
      end else begin
         if (wr.push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({wr.push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         wr.credit_return <= do_pop;  // slot back to the front end next cycle
      end
   end

   // head entry shown straight from the array
   assign rd.valid     = (count != '0);
   assign rd.word      = mem_word[rd_ptr];
   assign rd.word_time = mem_time[rd_ptr];

endmodule

// File: hdl/rx_frontend.sv
`timescale 1ns/1ps

module rx_frontend import rx_core_pkg::*; #(
   parameter int BUFF_DEPTH_LOG2 = 4
) (
   input  logic             radio_clk,
   input  logic             i_rst_n,
   input  sample_t          i_rx,
   input  logic             i_rx_stb,
   input  logic             i_pps,       // async, from the connector
   output logic             o_overflow,  // sticky until reset
   sample_credit_if.producer src
);

   localparam int CREDITS = 2**BUFF_DEPTH_LOG2;  // one per buffer slot
   localparam int CW      = BUFF_DEPTH_LOG2 + 1;

   logic          pps_meta, pps_sync, pps_dly;
   logic          pps_edge;
   time_t         time_cnt;
   logic          have_low;     // lower half of the pair is held
   sample_t       low_sample;
   time_t         low_time;
   logic          word_done;
   logic [CW-1:0] credit_cnt;

   ////////////////////////////////////////
   // pps sync and edge detect
   ////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= i_pps;     // may go metastable
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;  // edge register
      end
   end

   assign pps_edge = pps_sync & ~pps_dly;  // clear lands on the third edge

   // sample time, one tick per strobe
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         time_cnt <= '0;
      end else if (pps_edge) begin
         time_cnt <= '0;  // next strobe gets time 0
      end else if (i_rx_stb) begin
         time_cnt <= time_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // sample pairing
   ////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         have_low <= 1'b0;
      end else if (i_rx_stb) begin
         have_low <= ~have_low;
      end
   end

   // first sample of the pair and its time
   always_ff @(posedge radio_clk) begin
      if (i_rx_stb && !have_low) begin
         low_sample <= i_rx;
         low_time   <= time_cnt;
      end
   end

   assign word_done     = i_rx_stb & have_low;       // every second strobe
   assign src.push      = word_done & (credit_cnt != '0);
   assign src.word      = {i_rx, low_sample};        // first sample low
   assign src.word_time = low_time;

   ////////////////////////////////////////
   // credits and overflow
   ////////////////////////////////////////

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         credit_cnt <= CW'(CREDITS);  // buffer starts empty
         o_overflow <= 1'b0;
      end else begin
         case ({src.push, src.credit_return})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;  // none, or push and return together
         endcase
         if (word_done && credit_cnt == '0) begin
            o_overflow <= 1'b1;  // word dropped, radio can't stall
         end
      end
   end

endmodule

// File: hdl/word_read_if.sv
`timescale 1ns/1ps

interface word_read_if import rx_core_pkg::*; ();

   logic  valid;      // fifo not empty
   word_t word;       // head entry
   time_t word_time;  // head entry time
   logic  pop;        // take the head, only while valid

   modport buffer (
      output valid, word, word_time,
      input  pop
   );

   modport consumer (
      input  valid, word, word_time,
      output pop
   );

endinterface

// File: hdl/sample_credit_if.sv
`timescale 1ns/1ps

interface sample_credit_if import rx_core_pkg::*; ();

   logic  push;           // word valid this cycle, only with credit
   word_t word;           // two samples, first one low
   time_t word_time;      // time of the lower sample
   logic  credit_return;  // one slot freed in the buffer

   // front end side
   modport producer (
      output push, word, word_time,
      input  credit_return
   );

   // fifo side, accepts every push
   modport buffer (
      input  push, word, word_time,
      output credit_return
   );

endinterface

// File: hdl/rx_core_pkg.sv
package rx_core_pkg;

   ////////////////////////////////////////
   // datapath widths
   ////////////////////////////////////////

   // one adc sample, i and q packed
   typedef logic [31:0] sample_t;

   // stream word: two samples or one time value
   typedef logic [63:0] word_t;

   // sample-time count
   typedef logic [63:0] time_t;

   ////////////////////////////////////////
   // packetizer fsm
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,   // waiting for a head word
      ST_HEADER  = 2'd1,   // time beat on the bus
      ST_PAYLOAD = 2'd2    // sample words on the bus
   } pkt_state_t;

endpackage
